// ==== branchPredPkg.sv ====
// Shared widths, constants and packed types for the branch predictor.
// Instructions are fixed-size and aligned, so the two low address bits are dropped.
// Table sizes must stay powers of two to match the index widths below.
`default_nettype none

package branchPredPkg;

    localparam int FETCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;
    localparam int INSN_BYTES = 4;
    localparam int INSN_OFFSET_WIDTH = 2;
    localparam int PC_WIDTH = 32;

    localparam int PHT_ENTRIES = 64;
    localparam int PHT_INDEX_WIDTH = 6;
    localparam logic [1:0] PHT_INIT_VALUE = 2'd2;
    localparam int PHT_QUEUE_DEPTH = 4;

    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_WIDTH = 4;
    localparam int BTB_TAG_WIDTH = PC_WIDTH - BTB_INDEX_WIDTH - INSN_OFFSET_WIDTH;

    localparam logic [PC_WIDTH-1:0] RESET_PC = 32'h0000_1000;

    typedef logic [PC_WIDTH-1:0] pcT;
    typedef logic [PHT_INDEX_WIDTH-1:0] phtIndexT;

    // Upper bit set means predicted taken.
    typedef logic [1:0] phtCounterT;

    typedef struct packed {
        phtIndexT   index;
        phtCounterT value;
    } phtWriteT;

    // One resolved branch from the backend.
    typedef struct packed {
        logic       valid;
        pcT         pc;
        logic       taken;
        pcT         target;
        phtCounterT phtPrev;
    } brResultT;

    typedef struct packed {
        pcT         pc;
        logic       btbHit;
        logic       predTaken;
        phtCounterT phtCounter;
    } fetchSlotT;

    typedef struct packed {
        logic                             valid;
        fetchSlotT [FETCH_WIDTH-1:0]      slot;
        pcT                               predNextPc;
    } fetchGroupT;

    typedef enum logic {
        initWalk,
        initDone
    } initStateT;

endpackage

`default_nettype wire

// ==== phtRam.sv ====
// Counter storage with synchronous reads and one write port.
// Contents are undefined until the predictor's init walk has finished.
// A read and a write to the same index in one cycle return the old value.
`timescale 1ns/1ps
`default_nettype none

module phtRam (
    input  logic                      clk,
    input  branchPredPkg::phtIndexT   readIndex [branchPredPkg::FETCH_WIDTH],
    output branchPredPkg::phtCounterT readValue [branchPredPkg::FETCH_WIDTH],
    input  logic                      writeEnable,
    input  branchPredPkg::phtWriteT   write
);

    branchPredPkg::phtCounterT counters [branchPredPkg::PHT_ENTRIES];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            counters[write.index] <= write.value;
        end
    end

    // Both read ports sample the array before this edge's write lands.
    always_ff @(posedge clk) begin
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            readValue[i] <= counters[readIndex[i]];
        end
    end

endmodule

`default_nettype wire

// ==== phtUpdateQueue.sv ====
// Small circular FIFO holding PHT writes that lost the write port.
// A push while full is dropped, a pop while empty does nothing.
// popData shows the oldest entry and is meaningless while empty.
`timescale 1ns/1ps
`default_nettype none

module phtUpdateQueue (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    push,
    input  branchPredPkg::phtWriteT pushData,
    input  logic                    pop,
    output branchPredPkg::phtWriteT popData,
    output logic                    empty,
    output logic                    full
);

    branchPredPkg::phtWriteT entries [branchPredPkg::PHT_QUEUE_DEPTH];

    logic [$clog2(branchPredPkg::PHT_QUEUE_DEPTH)-1:0] headPtr;
    logic [$clog2(branchPredPkg::PHT_QUEUE_DEPTH)-1:0] tailPtr;
    logic [$clog2(branchPredPkg::PHT_QUEUE_DEPTH+1)-1:0] count;

    logic doPush;
    logic doPop;

    assign empty = (count == '0);
    assign full = (count == branchPredPkg::PHT_QUEUE_DEPTH);
    assign doPush = push && !full;
    assign doPop = pop && !empty;
    assign popData = entries[headPtr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= headPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone.
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[tailPtr] <= pushData;
        end
    end

endmodule

`default_nettype wire

// ==== bimodalPredictor.sv ====
// Bimodal direction predictor over a table of 2-bit counters.
// The backend returns the counter it was given at fetch, the update is computed from it.
// Only one PHT write per cycle, a second result waits in the update queue.
// After reset every counter is walked to weakly taken, initBusy covers that walk.
`timescale 1ns/1ps
`default_nettype none

module bimodalPredictor (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  branchPredPkg::pcT                    nextPc,
    input  logic [branchPredPkg::FETCH_WIDTH-1:0] btbHit,
    input  branchPredPkg::brResultT              brResult [branchPredPkg::ISSUE_WIDTH],
    output logic [branchPredPkg::FETCH_WIDTH-1:0] predTaken,
    output branchPredPkg::phtCounterT            phtCounter [branchPredPkg::FETCH_WIDTH],
    output logic                                 initBusy
);

    branchPredPkg::phtIndexT   readIndex [branchPredPkg::FETCH_WIDTH];
    branchPredPkg::phtCounterT readValue [branchPredPkg::FETCH_WIDTH];
    branchPredPkg::phtWriteT   resultWrite [branchPredPkg::ISSUE_WIDTH];

    logic                    directValid;
    branchPredPkg::phtWriteT directWrite;
    logic                    secondValid;
    branchPredPkg::phtWriteT secondWrite;

    logic                    queuePush;
    logic                    queuePop;
    branchPredPkg::phtWriteT queueHead;
    logic                    queueEmpty;
    logic                    queueFull;

    logic                    ramWriteEnable;
    branchPredPkg::phtWriteT ramWrite;

    branchPredPkg::initStateT initState;
    branchPredPkg::phtIndexT  initIndex;
    logic                     takenSeen;

    function automatic branchPredPkg::phtIndexT phtIndexOf(branchPredPkg::pcT pc);
        return pc[branchPredPkg::PHT_INDEX_WIDTH + branchPredPkg::INSN_OFFSET_WIDTH - 1 :
                  branchPredPkg::INSN_OFFSET_WIDTH];
    endfunction

    // Saturating up/down step.
    function automatic branchPredPkg::phtCounterT nextCounter(
        branchPredPkg::phtCounterT prev,
        logic taken
    );
        branchPredPkg::phtCounterT result;
        if (taken) begin
            result = (prev == '1) ? prev : prev + 1'b1;
        end else begin
            result = (prev == '0) ? prev : prev - 1'b1;
        end
        return result;
    endfunction

    phtRam phtRam_i (
        .clk        (clk),
        .readIndex  (readIndex),
        .readValue  (readValue),
        .writeEnable(ramWriteEnable),
        .write      (ramWrite)
    );

    phtUpdateQueue phtUpdateQueue_i (
        .clk     (clk),
        .rstN    (rstN),
        .push    (queuePush),
        .pushData(secondWrite),
        .pop     (queuePop),
        .popData (queueHead),
        .empty   (queueEmpty),
        .full    (queueFull)
    );

    assign initBusy = (initState == branchPredPkg::initWalk);

    // Read for the address being fetched next, data lines up with fetchPc.
    always_comb begin
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            readIndex[i] = phtIndexOf(branchPredPkg::pcT'(nextPc + i * branchPredPkg::INSN_BYTES));
        end
    end

    // A slot needs both a taken counter and a BTB target. Nothing after it is taken.
    always_comb begin
        takenSeen = 1'b0;
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            phtCounter[i] = readValue[i];
            predTaken[i] = readValue[i][1] && btbHit[i] && !takenSeen;
            takenSeen = takenSeen || predTaken[i];
        end
    end

    // Updated counter for each result slot.
    always_comb begin
        for (int i = 0; i < branchPredPkg::ISSUE_WIDTH; i++) begin
            resultWrite[i].index = phtIndexOf(brResult[i].pc);
            resultWrite[i].value = nextCounter(brResult[i].phtPrev, brResult[i].taken);
        end
    end

    // First valid result takes the port, a later one goes to the queue.
    always_comb begin
        directValid = 1'b0;
        directWrite = resultWrite[0];
        secondValid = 1'b0;
        secondWrite = resultWrite[branchPredPkg::ISSUE_WIDTH-1];
        for (int i = 0; i < branchPredPkg::ISSUE_WIDTH; i++) begin
            if (brResult[i].valid) begin
                if (!directValid) begin
                    directValid = 1'b1;
                    directWrite = resultWrite[i];
                end else begin
                    secondValid = 1'b1;
                    secondWrite = resultWrite[i];
                end
            end
        end
    end

    // Full queue drops the update.
    assign queuePush = secondValid && !queueFull && !initBusy;
    assign queuePop = !queueEmpty && !directValid && !initBusy;

    // Write port priority is init walk, then direct result, then queue.
    always_comb begin
        if (initBusy) begin
            ramWriteEnable = 1'b1;
            ramWrite.index = initIndex;
            ramWrite.value = branchPredPkg::PHT_INIT_VALUE;
        end else if (directValid) begin
            ramWriteEnable = 1'b1;
            ramWrite = directWrite;
        end else begin
            ramWriteEnable = queuePop;
            ramWrite = queueHead;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            initState <= branchPredPkg::initWalk;
            initIndex <= '0;
        end else if (initState == branchPredPkg::initWalk) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == branchPredPkg::phtIndexT'(branchPredPkg::PHT_ENTRIES - 1)) begin
                initState <= branchPredPkg::initDone;
            end
        end
    end

endmodule

`default_nettype wire

// ==== branchTargetBuffer.sv ====
// Direct-mapped, tagged branch target buffer looked up for both fetch slots.
// Lookups are registered and line up with the fetch address one cycle later.
// Only taken results allocate, an entry is never invalidated except by reset.
// When both results map to one entry, slot 1 is written last and wins.
`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  branchPredPkg::pcT                    readPc,
    input  branchPredPkg::brResultT              brResult [branchPredPkg::ISSUE_WIDTH],
    output logic [branchPredPkg::FETCH_WIDTH-1:0] btbHit,
    output branchPredPkg::pcT                    btbTarget [branchPredPkg::FETCH_WIDTH]
);

    logic [branchPredPkg::BTB_ENTRIES-1:0] entryValid;
    logic [branchPredPkg::BTB_TAG_WIDTH-1:0] entryTag [branchPredPkg::BTB_ENTRIES];
    branchPredPkg::pcT entryTarget [branchPredPkg::BTB_ENTRIES];

    logic [branchPredPkg::BTB_INDEX_WIDTH-1:0] readIndex [branchPredPkg::FETCH_WIDTH];
    logic [branchPredPkg::BTB_TAG_WIDTH-1:0]   readTag [branchPredPkg::FETCH_WIDTH];
    logic [branchPredPkg::BTB_INDEX_WIDTH-1:0] writeIndex [branchPredPkg::ISSUE_WIDTH];
    logic [branchPredPkg::BTB_TAG_WIDTH-1:0]   writeTag [branchPredPkg::ISSUE_WIDTH];

    // Split the address into index and tag above the byte offset.
    always_comb begin
        branchPredPkg::pcT slotPc;
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            slotPc = branchPredPkg::pcT'(readPc + i * branchPredPkg::INSN_BYTES);
            {readTag[i], readIndex[i]} =
                slotPc[branchPredPkg::PC_WIDTH-1:branchPredPkg::INSN_OFFSET_WIDTH];
        end
        for (int i = 0; i < branchPredPkg::ISSUE_WIDTH; i++) begin
            {writeTag[i], writeIndex[i]} =
                brResult[i].pc[branchPredPkg::PC_WIDTH-1:branchPredPkg::INSN_OFFSET_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
            btbHit <= '0;
        end else begin
            for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
                btbHit[i] <= entryValid[readIndex[i]] && (entryTag[readIndex[i]] == readTag[i]);
            end
            for (int i = 0; i < branchPredPkg::ISSUE_WIDTH; i++) begin
                if (brResult[i].valid && brResult[i].taken) begin
                    entryValid[writeIndex[i]] <= 1'b1;
                end
            end
        end
    end

    // Tags and targets only mean something where the valid bit is set.
    always_ff @(posedge clk) begin
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            btbTarget[i] <= entryTarget[readIndex[i]];
        end
        for (int i = 0; i < branchPredPkg::ISSUE_WIDTH; i++) begin
            if (brResult[i].valid && brResult[i].taken) begin
                entryTag[writeIndex[i]] <= writeTag[i];
                entryTarget[writeIndex[i]] <= brResult[i].target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fetchPcStage.sv ====
// Fetch address register and next-address selection.
// Priority is redirect, then hold (stall, init walk, first cycle after it), then prediction.
// nextPc is combinational and feeds the synchronous table reads directly.
`timescale 1ns/1ps
`default_nettype none

module fetchPcStage (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 stall,
    input  logic                                 redirectValid,
    input  branchPredPkg::pcT                    redirectPc,
    input  logic                                 initBusy,
    input  logic [branchPredPkg::FETCH_WIDTH-1:0] btbHit,
    input  branchPredPkg::pcT                    btbTarget [branchPredPkg::FETCH_WIDTH],
    input  logic [branchPredPkg::FETCH_WIDTH-1:0] predTaken,
    input  branchPredPkg::phtCounterT            phtCounter [branchPredPkg::FETCH_WIDTH],
    output branchPredPkg::pcT                    nextPc,
    output branchPredPkg::fetchGroupT            fetchGroup
);

    branchPredPkg::pcT fetchPc;
    branchPredPkg::pcT predNextPc;
    logic              groupValid;
    logic              takenFound;

    // First taken slot steers, otherwise step over the whole group.
    always_comb begin
        predNextPc = branchPredPkg::pcT'(fetchPc
            + branchPredPkg::FETCH_WIDTH * branchPredPkg::INSN_BYTES);
        takenFound = 1'b0;
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            if (predTaken[i] && !takenFound) begin
                predNextPc = btbTarget[i];
                takenFound = 1'b1;
            end
        end
    end

    // Holding one extra cycle after init lets the tables re-read RESET_PC.
    always_comb begin
        if (redirectValid) begin
            nextPc = redirectPc;
        end else if (stall || initBusy || !groupValid) begin
            nextPc = fetchPc;
        end else begin
            nextPc = predNextPc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchPc <= branchPredPkg::RESET_PC;
            groupValid <= 1'b0;
        end else begin
            fetchPc <= nextPc;
            groupValid <= !initBusy;
        end
    end

    always_comb begin
        fetchGroup.valid = groupValid;
        fetchGroup.predNextPc = predNextPc;
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            fetchGroup.slot[i].pc = branchPredPkg::pcT'(fetchPc + i * branchPredPkg::INSN_BYTES);
            fetchGroup.slot[i].btbHit = btbHit[i];
            fetchGroup.slot[i].predTaken = predTaken[i];
            fetchGroup.slot[i].phtCounter = phtCounter[i];
        end
    end

endmodule

`default_nettype wire

// ==== branchPredTop.sv ====
// Branch prediction front end for a single fetch path of two slots.
// redirectValid is a one-cycle strobe, stall is a level, both act on the next edge.
// fetchGroup is held invalid until the PHT init walk is over.
`timescale 1ns/1ps
`default_nettype none

module branchPredTop (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       stall,
    input  logic                       redirectValid,
    input  branchPredPkg::pcT          redirectPc,
    input  branchPredPkg::brResultT    brResult [branchPredPkg::ISSUE_WIDTH],
    output branchPredPkg::fetchGroupT  fetchGroup,
    output logic                       initBusy
);

    branchPredPkg::pcT                    nextPc;
    logic [branchPredPkg::FETCH_WIDTH-1:0] btbHit;
    branchPredPkg::pcT                    btbTarget [branchPredPkg::FETCH_WIDTH];
    logic [branchPredPkg::FETCH_WIDTH-1:0] predTaken;
    branchPredPkg::phtCounterT            phtCounter [branchPredPkg::FETCH_WIDTH];

    fetchPcStage fetchPcStage_i (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .initBusy     (initBusy),
        .btbHit       (btbHit),
        .btbTarget    (btbTarget),
        .predTaken    (predTaken),
        .phtCounter   (phtCounter),
        .nextPc       (nextPc),
        .fetchGroup   (fetchGroup)
    );

    branchTargetBuffer branchTargetBuffer_i (
        .clk      (clk),
        .rstN     (rstN),
        .readPc   (nextPc),
        .brResult (brResult),
        .btbHit   (btbHit),
        .btbTarget(btbTarget)
    );

    bimodalPredictor bimodalPredictor_i (
        .clk       (clk),
        .rstN      (rstN),
        .nextPc    (nextPc),
        .btbHit    (btbHit),
        .brResult  (brResult),
        .predTaken (predTaken),
        .phtCounter(phtCounter),
        .initBusy  (initBusy)
    );

endmodule

`default_nettype wire

// ==== branchPredTb.sv ====
// Directed testbench for the branch predictor front end.
// A model of the PHT counters and the BTB gives the expected fetch groups.
// The tests never fill the PHT update queue, so no update is modeled as dropped.
`timescale 1ns/1ps
`default_nettype none

module branchPredTb;

    localparam int RESET_CYCLES = 16;
    localparam int TEST_BUDGET = 480;
    // Reset and init walk, then a generous budget for each of the six tests.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + branchPredPkg::PHT_ENTRIES + 6 * TEST_BUDGET;

    logic                      clk;
    logic                      rstN;
    logic                      stall;
    logic                      redirectValid;
    branchPredPkg::pcT         redirectPc;
    branchPredPkg::brResultT   brResult [branchPredPkg::ISSUE_WIDTH];
    branchPredPkg::fetchGroupT fetchGroup;
    logic                      initBusy;

    // Reference model state.
    branchPredPkg::phtCounterT refPht [branchPredPkg::PHT_ENTRIES];
    logic refBtbValid [branchPredPkg::BTB_ENTRIES];
    logic [branchPredPkg::BTB_TAG_WIDTH-1:0] refBtbTag [branchPredPkg::BTB_ENTRIES];
    branchPredPkg::pcT refBtbTarget [branchPredPkg::BTB_ENTRIES];

    int errorCount = 0;
    int failedTests = 0;
    int testCount = 0;
    int cycleCount = 0;
    branchPredPkg::pcT branchA;

    branchPredTop branchPredTop_i (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .brResult     (brResult),
        .fetchGroup   (fetchGroup),
        .initBusy     (initBusy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic branchPredPkg::phtIndexT phtSlot(branchPredPkg::pcT pc);
        return pc[branchPredPkg::PHT_INDEX_WIDTH+1:2];
    endfunction

    function automatic logic [branchPredPkg::BTB_INDEX_WIDTH-1:0] btbSlot(branchPredPkg::pcT pc);
        return pc[branchPredPkg::BTB_INDEX_WIDTH+1:2];
    endfunction

    function automatic logic [branchPredPkg::BTB_TAG_WIDTH-1:0] btbTagOf(branchPredPkg::pcT pc);
        return pc[branchPredPkg::PC_WIDTH-1:branchPredPkg::BTB_INDEX_WIDTH+2];
    endfunction

    // Saturates at 3 on taken and at 0 on not taken.
    function automatic branchPredPkg::phtCounterT stepCounter(
        branchPredPkg::phtCounterT prev,
        logic taken
    );
        if (taken) begin
            return (prev == 2'd3) ? prev : prev + 2'd1;
        end else begin
            return (prev == 2'd0) ? prev : prev - 2'd1;
        end
    endfunction

    function automatic branchPredPkg::brResultT makeResult(
        branchPredPkg::pcT pc,
        logic taken,
        branchPredPkg::pcT target,
        branchPredPkg::phtCounterT prev
    );
        branchPredPkg::brResultT r;
        r.valid = 1'b1;
        r.pc = pc;
        r.taken = taken;
        r.target = target;
        r.phtPrev = prev;
        return r;
    endfunction

    function automatic void applyResult(branchPredPkg::brResultT r);
        if (r.valid) begin
            refPht[phtSlot(r.pc)] = stepCounter(r.phtPrev, r.taken);
            if (r.taken) begin
                refBtbValid[btbSlot(r.pc)] = 1'b1;
                refBtbTag[btbSlot(r.pc)] = btbTagOf(r.pc);
                refBtbTarget[btbSlot(r.pc)] = r.target;
            end
        end
    endfunction

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        assert (actual === expected) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errorCount++;
        end
    endtask

    // Compares the current fetch group against the model for a group at expPc.
    task automatic checkGroup(branchPredPkg::pcT expPc);
        branchPredPkg::pcT pc;
        branchPredPkg::pcT expNext;
        logic hit;
        logic taken;
        logic takenSeen;
        expNext = expPc + 32'd8;
        takenSeen = 1'b0;
        checkValue("fetchGroup.valid", fetchGroup.valid, 1);
        for (int i = 0; i < branchPredPkg::FETCH_WIDTH; i++) begin
            pc = expPc + 32'(4 * i);
            hit = refBtbValid[btbSlot(pc)] && (refBtbTag[btbSlot(pc)] == btbTagOf(pc));
            taken = refPht[phtSlot(pc)][1] && hit && !takenSeen;
            if (taken) begin
                expNext = refBtbTarget[btbSlot(pc)];
            end
            takenSeen = takenSeen || taken;
            checkValue($sformatf("slot[%0d].pc", i), fetchGroup.slot[i].pc, pc);
            checkValue($sformatf("slot[%0d].btbHit", i), fetchGroup.slot[i].btbHit, hit);
            checkValue($sformatf("slot[%0d].phtCounter", i), fetchGroup.slot[i].phtCounter,
                refPht[phtSlot(pc)]);
            checkValue($sformatf("slot[%0d].predTaken", i), fetchGroup.slot[i].predTaken, taken);
        end
        checkValue("fetchGroup.predNextPc", fetchGroup.predNextPc, expNext);
    endtask

    task automatic sendResults(branchPredPkg::brResultT r0, branchPredPkg::brResultT r1);
        @(posedge clk);
        brResult[0] <= r0;
        brResult[1] <= r1;
        applyResult(r0);
        applyResult(r1);
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            @(posedge clk);
            redirectValid <= 1'b0;
            brResult[0] <= '0;
            brResult[1] <= '0;
        end
    endtask

    // Ends at the negedge where the group fetched from pc is visible.
    task automatic redirectTo(branchPredPkg::pcT pc);
        @(posedge clk);
        brResult[0] <= '0;
        brResult[1] <= '0;
        redirectValid <= 1'b1;
        redirectPc <= pc;
        @(posedge clk);
        redirectValid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic finishTest(string name, int startErrors);
        testCount++;
        if (errorCount > startErrors) begin
            failedTests++;
            $display("Test %s failed with %0d errors", name, errorCount - startErrors);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    task automatic initTest();
        int startErrors;
        int busyCycles;
        startErrors = errorCount;
        busyCycles = 0;
        @(negedge clk);
        while (initBusy && busyCycles <= 2 * branchPredPkg::PHT_ENTRIES) begin
            checkValue("fetchGroup.valid", fetchGroup.valid, 0);
            busyCycles++;
            @(negedge clk);
        end
        checkValue("initBusy cycles", busyCycles, branchPredPkg::PHT_ENTRIES);
        checkValue("fetchGroup.valid", fetchGroup.valid, 0);
        @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            checkGroup(branchPredPkg::RESET_PC + 32'(8 * k));
            @(negedge clk);
        end
        finishTest("init", startErrors);
    endtask

    task automatic takenTest();
        int startErrors;
        branchPredPkg::pcT target;
        startErrors = errorCount;
        branchA = 32'h0001_0000 | ($urandom & 32'h0000_fffc);
        target = 32'h0002_0000 | ($urandom & 32'h0000_fffc);
        sendResults(makeResult(branchA, 1'b1, target, refPht[phtSlot(branchA)]), '0);
        redirectTo(branchA);
        checkGroup(branchA);
        checkValue("slot[0].phtCounter", fetchGroup.slot[0].phtCounter, 3);
        checkValue("fetchGroup.predNextPc", fetchGroup.predNextPc, target);
        @(negedge clk);
        checkGroup(target);
        finishTest("taken prediction", startErrors);
    endtask

    task automatic saturationTest();
        int startErrors;
        branchPredPkg::phtCounterT seen;
        startErrors = errorCount;
        for (int n = 0; n < 4; n++) begin
            redirectTo(branchA);
            checkGroup(branchA);
            seen = fetchGroup.slot[0].phtCounter;
            sendResults(makeResult(branchA, 1'b0, '0, seen), '0);
        end
        redirectTo(branchA);
        checkGroup(branchA);
        checkValue("slot[0].phtCounter", fetchGroup.slot[0].phtCounter, 0);
        checkValue("slot[0].btbHit", fetchGroup.slot[0].btbHit, 1);
        checkValue("slot[0].predTaken", fetchGroup.slot[0].predTaken, 0);
        finishTest("counter saturation", startErrors);
    endtask

    // Slot 1 of the result pair goes through the update queue.
    task automatic queueTest();
        int startErrors;
        branchPredPkg::pcT b;
        startErrors = errorCount;
        b = 32'h0004_0000 | ($urandom & 32'h0000_fff8);
        sendResults(makeResult(b, 1'b0, '0, refPht[phtSlot(b)]),
            makeResult(b + 32'd4, 1'b1, b + 32'h100, refPht[phtSlot(b + 32'd4)]));
        idleCycles(4);
        redirectTo(b);
        checkGroup(b);
        finishTest("dual results", startErrors);
    endtask

    task automatic stallTest();
        int startErrors;
        branchPredPkg::pcT held;
        branchPredPkg::pcT target;
        startErrors = errorCount;
        redirectTo(32'h0005_0000);
        @(posedge clk);
        stall <= 1'b1;
        // No branch is installed near this address, so the edge that raises
        // stall still steps past the redirected group.
        held = 32'h0005_0000 + 32'd8;
        repeat (5) begin
            @(negedge clk);
            checkValue("slot[0].pc", fetchGroup.slot[0].pc, held);
        end
        target = 32'h0006_0000 | ($urandom & 32'h0000_fffc);
        @(posedge clk);
        redirectValid <= 1'b1;
        redirectPc <= target;
        @(posedge clk);
        redirectValid <= 1'b0;
        @(negedge clk);
        checkGroup(target);
        repeat (3) begin
            @(negedge clk);
            checkGroup(target);
        end
        @(posedge clk);
        stall <= 1'b0;
        finishTest("stall and redirect", startErrors);
    endtask

    task automatic firstTakenTest();
        int startErrors;
        branchPredPkg::pcT c;
        branchPredPkg::pcT target0;
        startErrors = errorCount;
        c = 32'h0007_0000 | ($urandom & 32'h0000_fff8);
        target0 = 32'h0008_0000 | ($urandom & 32'h0000_fffc);
        // Three rounds lift even a counter at 0 to taken.
        repeat (3) begin
            sendResults(makeResult(c, 1'b1, target0, refPht[phtSlot(c)]),
                makeResult(c + 32'd4, 1'b1, target0 + 32'h40, refPht[phtSlot(c + 32'd4)]));
            idleCycles(3);
        end
        redirectTo(c);
        checkGroup(c);
        checkValue("slot[0].predTaken", fetchGroup.slot[0].predTaken, 1);
        checkValue("slot[1].btbHit", fetchGroup.slot[1].btbHit, 1);
        checkValue("slot[1].predTaken", fetchGroup.slot[1].predTaken, 0);
        checkValue("fetchGroup.predNextPc", fetchGroup.predNextPc, target0);
        finishTest("first taken slot", startErrors);
    endtask

    initial begin
        void'($urandom(38));
        rstN = 1'b0;
        stall = 1'b0;
        redirectValid = 1'b0;
        redirectPc = '0;
        for (int i = 0; i < branchPredPkg::ISSUE_WIDTH; i++) begin
            brResult[i] = '0;
        end
        for (int i = 0; i < branchPredPkg::PHT_ENTRIES; i++) begin
            refPht[i] = branchPredPkg::PHT_INIT_VALUE;
        end
        for (int i = 0; i < branchPredPkg::BTB_ENTRIES; i++) begin
            refBtbValid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        initTest();
        takenTest();
        saturationTest();
        queueTest();
        stallTest();
        firstTakenTest();
        $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
            testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
branchPredPkg.sv
phtRam.sv
phtUpdateQueue.sv
bimodalPredictor.sv
branchTargetBuffer.sv
fetchPcStage.sv
branchPredTop.sv
branchPredTb.sv

// ==== Makefile ====
# Verilator build and run for the branch predictor testbench.

TOP := branchPredTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

# Pass only if the pass line shows up in the simulation output.
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Everything OK" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
